// ==== Bender.yml ====
package:
  name: conv1

sources:
  - design/conv1_pkg.sv
  - design/conv1_apb_regs.sv
  - design/conv1_sequencer.sv
  - design/kernel_buffer.sv
  - design/row_mac.sv
  - design/psum_accum.sv
  - design/pool_quant_write.sv
  - design/conv1_top.sv
  - target: test
    files:
      - verification/conv1_checker.sv
      - verification/tb_conv1.sv

// ==== design/conv1_apb_regs.sv ====
`timescale 1ns/1ps

module conv1_apb_regs
    import conv1_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  addr_t       paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output scale_t      scale,
    output logic        start,
    input  logic        done
);

    logic wr_access;

    assign wr_access = psel && penable && pwrite;

    // no wait states
    assign pready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scale <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_access && (paddr == REG_CTRL) && pwdata[0];
            if (wr_access && (paddr == REG_SCALE)) begin
                scale <= pwdata;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_SCALE:  prdata = scale;
            REG_STATUS: prdata = {31'b0, done};
            default:    prdata = '0;
        endcase
    end

    // access phase only after a setup phase
    assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel && $past(psel && !penable));

endmodule

// ==== design/conv1_pkg.sv ====
package conv1_pkg;

    localparam int KSIZE = 5;
    localparam int LANES = 4;

    typedef logic signed [7:0]  pix_t;
    typedef logic [31:0]        act_word_t;
    typedef logic signed [31:0] psum_t;
    typedef logic [31:0]        scale_t;
    typedef logic [15:0]        addr_t;
    // activation row inside a block, 0..KSIZE
    typedef logic [2:0]         row_idx_t;

    // weight 0 sits in the low byte
    typedef pix_t [KSIZE-1:0] kernel_row_t;

    typedef struct packed {
        psum_t [LANES-1:0] row1;
        psum_t [LANES-1:0] row0;
    } psum_blk_t;

    typedef struct packed {
        logic [7:0] ch;
        logic [7:0] prow;
        logic [7:0] cgrp;
    } blk_tag_t;

    typedef struct packed {
        logic     valid;
        logic     first;
        logic     last;
        row_idx_t row;
        blk_tag_t tag;
    } mac_in_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_KERNEL,
        READ_ACT,
        DRAIN,
        NEXT_CHANNEL,
        DONE
    } seq_state_t;

    localparam addr_t REG_SCALE  = 16'h0;
    localparam addr_t REG_CTRL   = 16'h4;
    localparam addr_t REG_STATUS = 16'h8;

endpackage

// ==== design/conv1_sequencer.sv ====
`timescale 1ns/1ps

module conv1_sequencer
    import conv1_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_CH   = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    output addr_t    wt_addr0,
    output addr_t    wt_addr1,
    output addr_t    act_addr0,
    output addr_t    act_addr1,
    output logic     kload,
    output row_idx_t kload_row,
    output mac_in_t  item,
    output logic     done
);

    localparam int P            = (IMG_SIZE - 4) / 2;
    localparam int G            = (IMG_SIZE - 4) / 4;
    localparam int ROW_WORDS    = IMG_SIZE / 4;
    localparam int IMG_WORDS    = IMG_SIZE * ROW_WORDS;
    localparam int KWORDS       = 2 * KSIZE;
    localparam int DRAIN_CYCLES = 4;

    seq_state_t state;
    logic [7:0] ch;
    logic [7:0] prow;
    logic [7:0] cgrp;
    row_idx_t   krow;
    row_idx_t   arow;
    logic [2:0] drain_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            ch        <= '0;
            prow      <= '0;
            cgrp      <= '0;
            krow      <= '0;
            arow      <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= LOAD_KERNEL;
                        ch    <= '0;
                        krow  <= '0;
                    end
                end
                LOAD_KERNEL: begin
                    krow <= krow + 1'b1;
                    if (krow == row_idx_t'(KSIZE - 1)) begin
                        state <= READ_ACT;
                        prow  <= '0;
                        cgrp  <= '0;
                        arow  <= '0;
                    end
                end
                READ_ACT: begin
                    arow <= arow + 1'b1;
                    // six rows per block, then next group / pooled row / channel
                    if (arow == row_idx_t'(KSIZE)) begin
                        arow <= '0;
                        cgrp <= cgrp + 1'b1;
                        if (cgrp == 8'(G - 1)) begin
                            cgrp <= '0;
                            prow <= prow + 1'b1;
                            if (prow == 8'(P - 1)) begin
                                prow <= '0;
                                if (ch == 8'(OUT_CH - 1)) begin
                                    state     <= DRAIN;
                                    drain_cnt <= '0;
                                end else begin
                                    state <= NEXT_CHANNEL;
                                end
                            end
                        end
                    end
                end
                NEXT_CHANNEL: begin
                    ch    <= ch + 1'b1;
                    krow  <= '0;
                    state <= LOAD_KERNEL;
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 3'(DRAIN_CYCLES - 1)) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        wt_addr0  = '0;
        wt_addr1  = '0;
        act_addr0 = '0;
        act_addr1 = '0;
        kload     = 1'b0;
        kload_row = krow;
        item      = '0;
        case (state)
            LOAD_KERNEL: begin
                wt_addr0 = addr_t'(int'(ch) * KWORDS + 2 * int'(krow));
                wt_addr1 = addr_t'(int'(ch) * KWORDS + 2 * int'(krow) + 1);
                kload    = 1'b1;
            end
            READ_ACT: begin
                act_addr0 = addr_t'((2 * int'(prow) + int'(arow)) * ROW_WORDS + int'(cgrp));
                act_addr1 = addr_t'((2 * int'(prow) + int'(arow)) * ROW_WORDS + int'(cgrp) + 1);
                item.valid    = 1'b1;
                item.first    = (arow == '0);
                item.last     = (arow == row_idx_t'(KSIZE));
                item.row      = arow;
                item.tag.ch   = ch;
                item.tag.prow = prow;
                item.tag.cgrp = cgrp;
            end
            default: begin
            end
        endcase
    end

    assign done = (state == DONE);

    assert property (@(posedge clk) disable iff (!rst_n)
        item.valid |-> act_addr1 < addr_t'(IMG_WORDS));

endmodule

// ==== design/conv1_top.sv ====
`timescale 1ns/1ps

module conv1_top
    import conv1_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_CH   = 2,
    parameter int OUT_BASE = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  addr_t       paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output addr_t       wt_addr0,
    output addr_t       wt_addr1,
    input  act_word_t   wt_rdata0,
    input  act_word_t   wt_rdata1,
    output addr_t       act_addr0,
    output addr_t       act_addr1,
    input  act_word_t   act_rdata0,
    input  act_word_t   act_rdata1,
    output logic        out_we,
    output addr_t       out_addr,
    output logic [3:0]  out_be,
    output act_word_t   out_wdata,
    output logic        done
);

    scale_t      scale;
    logic        start;
    mac_in_t     item;
    mac_in_t     item_d;
    mac_in_t     item_mac;
    logic        kload;
    logic        kload_d;
    row_idx_t    kload_row;
    row_idx_t    kload_row_d;
    kernel_row_t krow_top;
    kernel_row_t krow_bot;
    psum_blk_t   prod;
    psum_blk_t   blk;
    logic        blk_valid;
    blk_tag_t    blk_tag;

    conv1_apb_regs u_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .scale, .start, .done
    );

    conv1_sequencer #(.IMG_SIZE(IMG_SIZE), .OUT_CH(OUT_CH)) u_seq (
        .clk, .rst_n, .start, .wt_addr0, .wt_addr1, .act_addr0, .act_addr1,
        .kload, .kload_row, .item, .done
    );

    // match the 1-cycle memory read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            item_d  <= '0;
            kload_d <= 1'b0;
        end else begin
            item_d  <= item;
            kload_d <= kload;
        end
    end

    always_ff @(posedge clk) begin
        kload_row_d <= kload_row;
    end

    kernel_buffer u_kbuf (
        .clk, .rst_n, .kload(kload_d), .kload_row(kload_row_d),
        .wt_rdata0, .wt_rdata1, .item(item_d), .krow_top, .krow_bot
    );

    row_mac u_mac (
        .clk, .rst_n, .act_rdata0, .act_rdata1, .krow_top, .krow_bot,
        .item_in(item_d), .prod, .item_out(item_mac)
    );

    psum_accum u_acc (
        .clk, .rst_n, .prod, .item(item_mac), .blk, .blk_valid, .blk_tag
    );

    pool_quant_write #(.IMG_SIZE(IMG_SIZE), .OUT_BASE(OUT_BASE)) u_pqw (
        .clk, .rst_n, .blk, .blk_valid, .blk_tag, .scale,
        .out_we, .out_addr, .out_be, .out_wdata
    );

endmodule

// ==== design/kernel_buffer.sv ====
`timescale 1ns/1ps

module kernel_buffer
    import conv1_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        kload,
    input  row_idx_t    kload_row,
    input  act_word_t   wt_rdata0,
    input  act_word_t   wt_rdata1,
    input  mac_in_t     item,
    output kernel_row_t krow_top,
    output kernel_row_t krow_bot
);

    kernel_row_t      kmem [KSIZE];
    logic [KSIZE-1:0] loaded;

    // row k is four bytes of one word plus byte 0 of the next
    always_ff @(posedge clk) begin
        if (kload) begin
            kmem[kload_row] <= {wt_rdata1[7:0], wt_rdata0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loaded <= '0;
        end else if (kload) begin
            loaded[kload_row] <= 1'b1;
        end
    end

    // row r feeds output row 0 with kernel row r, output row 1 with r-1
    always_comb begin
        krow_top = '0;
        krow_bot = '0;
        if (item.valid) begin
            if (item.row < row_idx_t'(KSIZE)) begin
                krow_top = kmem[item.row];
            end
            if (item.row != '0) begin
                krow_bot = kmem[item.row - 1'b1];
            end
        end
    end

    // kernel must be complete before any activation row arrives
    assert property (@(posedge clk) disable iff (!rst_n)
        item.valid |-> &loaded);

endmodule

// ==== design/pool_quant_write.sv ====
`timescale 1ns/1ps

module pool_quant_write
    import conv1_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_BASE = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    input  psum_blk_t blk,
    input  logic      blk_valid,
    input  blk_tag_t  blk_tag,
    input  scale_t    scale,
    output logic      out_we,
    output addr_t     out_addr,
    output logic [3:0] out_be,
    output act_word_t out_wdata
);

    localparam int P = (IMG_SIZE - 4) / 2;
    localparam int G = (IMG_SIZE - 4) / 4;

    logic [7:0] q_even;
    logic [7:0] q_odd;

    function automatic logic [7:0] pool_quant(
        input psum_t  a0,
        input psum_t  a1,
        input psum_t  b0,
        input psum_t  b1,
        input scale_t s
    );
        psum_t       lane0;
        psum_t       lane1;
        psum_t       pooled;
        logic [63:0] scaled;
        // rows first, then the lane pair
        lane0  = (a0 > b0) ? a0 : b0;
        lane1  = (a1 > b1) ? a1 : b1;
        pooled = (lane0 > lane1) ? lane0 : lane1;
        if (pooled < 0) begin
            pooled = '0;
        end
        scaled = {32'b0, pooled} * {32'b0, s};
        // saturate anything at or above bit 23
        return (|scaled[63:23]) ? 8'd127 : scaled[23:16];
    endfunction

    assign q_even = pool_quant(blk.row0[0], blk.row0[1], blk.row1[0], blk.row1[1], scale);
    assign q_odd  = pool_quant(blk.row0[2], blk.row0[3], blk.row1[2], blk.row1[3], scale);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_we <= 1'b0;
            out_be <= '0;
        end else begin
            out_we <= blk_valid;
            out_be <= blk_valid ? 4'b0011 : 4'b0000;
        end
    end

    // one halfword per column group
    always_ff @(posedge clk) begin
        if (blk_valid) begin
            out_addr  <= addr_t'(OUT_BASE + int'(blk_tag.ch) * P * G
                                 + int'(blk_tag.prow) * G + int'(blk_tag.cgrp));
            out_wdata <= {16'b0, q_odd, q_even};
        end
    end

endmodule

// ==== design/psum_accum.sv ====
`timescale 1ns/1ps

module psum_accum
    import conv1_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  psum_blk_t prod,
    input  mac_in_t   item,
    output psum_blk_t blk,
    output logic      blk_valid,
    output blk_tag_t  blk_tag
);

    psum_blk_t acc;
    logic      in_block;

    // running sum plus the current row
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            blk.row0[j] = acc.row0[j] + prod.row0[j];
            blk.row1[j] = acc.row1[j] + prod.row1[j];
        end
    end

    assign blk_valid = item.valid && item.last;
    assign blk_tag   = item.tag;

    always_ff @(posedge clk) begin
        if (item.valid) begin
            acc <= item.first ? prod : blk;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_block <= 1'b0;
        end else if (item.valid && item.first) begin
            in_block <= 1'b1;
        end else if (item.valid && item.last) begin
            in_block <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        item.valid && item.first |-> !in_block);

    assert property (@(posedge clk) disable iff (!rst_n)
        item.valid && !item.first |-> in_block);

endmodule

// ==== design/row_mac.sv ====
`timescale 1ns/1ps

module row_mac
    import conv1_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  act_word_t   act_rdata0,
    input  act_word_t   act_rdata1,
    input  kernel_row_t krow_top,
    input  kernel_row_t krow_bot,
    input  mac_in_t     item_in,
    output psum_blk_t   prod,
    output mac_in_t     item_out
);

    pix_t [2*LANES-1:0] px;
    psum_blk_t          sum;

    // eight pixels, leftmost in the low byte of word 0
    assign px = {act_rdata1, act_rdata0};

    always_comb begin
        sum = '0;
        for (int j = 0; j < LANES; j++) begin
            for (int i = 0; i < KSIZE; i++) begin
                sum.row0[j] += psum_t'(krow_top[i]) * psum_t'(px[j + i]);
                sum.row1[j] += psum_t'(krow_bot[i]) * psum_t'(px[j + i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        prod <= sum;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            item_out <= '0;
        end else begin
            item_out <= item_in;
        end
    end

endmodule

// ==== flist.f ====
design/conv1_pkg.sv
design/conv1_apb_regs.sv
design/conv1_sequencer.sv
design/kernel_buffer.sv
design/row_mac.sv
design/psum_accum.sv
design/pool_quant_write.sv
design/conv1_top.sv
verification/conv1_checker.sv
verification/tb_conv1.sv

// ==== verification/conv1_checker.sv ====
`timescale 1ns/1ps

module conv1_checker
    import conv1_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_CH   = 2,
    parameter int OUT_BASE = 256
) (
    input logic       clk,
    input logic       rst_n,
    input logic       out_we,
    input addr_t      out_addr,
    input logic [3:0] out_be,
    input act_word_t  out_wdata,
    input logic       done
);

    localparam int P         = (IMG_SIZE - 4) / 2;
    localparam int G         = (IMG_SIZE - 4) / 4;
    localparam int ROW_WORDS = IMG_SIZE / 4;
    localparam int TOTAL     = OUT_CH * P * G;

    act_word_t exp_word [TOTAL];
    logic      seen [TOTAL];
    int        err_count    = 0;
    int        write_count  = 0;
    int        sat_seen     = 0;
    int        sat_expected = 0;
    logic      run_active   = 1'b0;
    logic      done_q       = 1'b0;

    function automatic int pixel_at(input int y, input int x);
        act_word_t w;
        pix_t      v;
        w = tb_conv1.act_mem[y * ROW_WORDS + x / 4];
        v = w[8 * (x % 4) +: 8];
        return int'(v);
    endfunction

    // weights 0..3 in one word, weight 4 in byte 0 of the next
    function automatic int weight_at(input int c, input int r, input int i);
        act_word_t w;
        pix_t      v;
        w = tb_conv1.wt_mem[c * 2 * KSIZE + 2 * r + i / 4];
        v = w[8 * (i % 4) +: 8];
        return int'(v);
    endfunction

    function automatic int conv_at(input int c, input int y, input int x);
        int acc;
        acc = 0;
        for (int r = 0; r < KSIZE; r++) begin
            for (int i = 0; i < KSIZE; i++) begin
                acc += weight_at(c, r, i) * pixel_at(y + r, x + i);
            end
        end
        return acc;
    endfunction

    task automatic note_failure(input string msg);
        $display("%0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, expected);
            err_count++;
        end
    endtask

    // reference model for one run, taken from the memories as filled now
    task automatic expect_run(input scale_t s, input int sat_target);
        int          best;
        int          v;
        int          idx;
        int          model_sat;
        logic [63:0] scaled;
        logic [7:0]  q;
        model_sat = 0;
        for (int c = 0; c < OUT_CH; c++) begin
            for (int pr = 0; pr < P; pr++) begin
                for (int pc = 0; pc < 2 * G; pc++) begin
                    best = conv_at(c, 2 * pr, 2 * pc);
                    for (int d = 1; d < 4; d++) begin
                        v = conv_at(c, 2 * pr + d / 2, 2 * pc + d % 2);
                        if (v > best) begin
                            best = v;
                        end
                    end
                    if (best < 0) begin
                        best = 0;
                    end
                    scaled = 64'(best) * 64'(s);
                    q = (scaled >= 64'h80_0000) ? 8'd127 : scaled[23:16];
                    if (q == 8'd127) begin
                        model_sat++;
                    end
                    idx = c * P * G + pr * G + pc / 2;
                    if (pc % 2 == 0) begin
                        exp_word[idx] = {24'b0, q};
                    end else begin
                        exp_word[idx][15:8] = q;
                    end
                end
            end
        end
        sat_expected = (sat_target >= 0) ? sat_target : model_sat;
        for (int i = 0; i < TOTAL; i++) begin
            seen[i] = 1'b0;
        end
        write_count = 0;
        sat_seen    = 0;
        run_active  = 1'b1;
    endtask

    task automatic finish_run();
        if (write_count != TOTAL) begin
            note_failure($sformatf("%0d output writes seen, %0d expected", write_count, TOTAL));
        end
        check_value("sat_count", sat_seen, sat_expected);
        run_active = 1'b0;
    endtask

    always @(posedge clk) begin : watch_writes
        int idx;
        if (rst_n && out_we) begin
            idx = int'(out_addr) - OUT_BASE;
            if (!run_active) begin
                note_failure("output write outside a run");
            end else if (done) begin
                note_failure("output write while done is high");
            end
            if (idx < 0 || idx >= TOTAL) begin
                note_failure($sformatf("output write to address %0d outside the map", out_addr));
            end else if (seen[idx]) begin
                note_failure($sformatf("second output write to address %0d", out_addr));
            end else begin
                seen[idx] = 1'b1;
                write_count++;
                check_value("out_be", 32'(out_be), 32'h3);
                check_value($sformatf("out_wdata @%0d", out_addr), out_wdata, exp_word[idx]);
                sat_seen += (out_wdata[7:0] == 8'd127) + (out_wdata[15:8] == 8'd127);
            end
        end
        if (rst_n && done && !done_q && run_active && write_count != TOTAL) begin
            note_failure("done rose before all output writes");
        end
        done_q = done;
    end

endmodule

// ==== verification/tb_conv1.sv ====
`timescale 1ns/1ps

module tb_conv1
    import conv1_pkg::*;
();

    localparam int IMG_SIZE    = 12;
    localparam int OUT_CH      = 2;
    localparam int OUT_BASE    = 256;
    localparam int P           = (IMG_SIZE - 4) / 2;
    localparam int G           = (IMG_SIZE - 4) / 4;
    localparam int ROW_WORDS   = IMG_SIZE / 4;
    localparam int ROWS        = 4;
    localparam int WATCHDOG_NS = ROWS * OUT_CH * (5 + P * G * 6 + 10) * 8 * 4;

    typedef enum logic [1:0] {FILL_ONES, FILL_ALT, FILL_RAND} fill_t;

    // one table row, sat < 0 means take the count from the model
    typedef struct packed {
        scale_t scale;
        fill_t  kfill;
        fill_t  ifill;
        int     sat;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    addr_t       paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    addr_t       wt_addr0;
    addr_t       wt_addr1;
    act_word_t   wt_rdata0;
    act_word_t   wt_rdata1;
    addr_t       act_addr0;
    addr_t       act_addr1;
    act_word_t   act_rdata0;
    act_word_t   act_rdata1;
    logic        out_we;
    addr_t       out_addr;
    logic [3:0]  out_be;
    act_word_t   out_wdata;
    logic        done;

    act_word_t   wt_mem [OUT_CH * 2 * KSIZE];
    act_word_t   act_mem [IMG_SIZE * ROW_WORDS];
    test_row_t   table_rows [ROWS];
    logic [31:0] lcg_state = 32'd8;

    conv1_top #(.IMG_SIZE(IMG_SIZE), .OUT_CH(OUT_CH), .OUT_BASE(OUT_BASE)) dut (.*);

    conv1_checker #(.IMG_SIZE(IMG_SIZE), .OUT_CH(OUT_CH), .OUT_BASE(OUT_BASE)) chk (
        .clk(clk), .rst_n(rst_n), .out_we(dut.out_we), .out_addr(dut.out_addr),
        .out_be(dut.out_be), .out_wdata(dut.out_wdata), .done(dut.done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both memories answer one cycle after the address
    always @(posedge clk) begin
        wt_rdata0  <= #1 wt_mem[wt_addr0];
        wt_rdata1  <= #1 wt_mem[wt_addr1];
        act_rdata0 <= #1 act_mem[act_addr0];
        act_rdata1 <= #1 act_mem[act_addr1];
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    function automatic logic [7:0] fill_value(input fill_t mode, input int parity);
        case (mode)
            FILL_ONES: return 8'sd1;
            FILL_ALT:  return (parity % 2 != 0) ? -8'sd1 : 8'sd1;
            default:   return lcg_byte();
        endcase
    endfunction

    function automatic test_row_t make_row(input scale_t s, input fill_t kf, input fill_t imf,
                                           input int sat);
        test_row_t t;
        t.scale = s;
        t.kfill = kf;
        t.ifill = imf;
        t.sat   = sat;
        return t;
    endfunction

    task automatic fill_memories(input test_row_t t);
        int w;
        for (int n = 0; n < OUT_CH * 2 * KSIZE; n++) begin
            wt_mem[n] = '0;
        end
        for (int c = 0; c < OUT_CH; c++) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int i = 0; i < KSIZE; i++) begin
                    w = c * 2 * KSIZE + 2 * r + i / 4;
                    wt_mem[w][8 * (i % 4) +: 8] = fill_value(t.kfill, c + r + i);
                end
            end
        end
        for (int y = 0; y < IMG_SIZE; y++) begin
            for (int x = 0; x < IMG_SIZE; x++) begin
                w = y * ROW_WORDS + x / 4;
                act_mem[w][8 * (x % 4) +: 8] = fill_value(t.ifill, y + x);
            end
        end
    endtask

    task automatic apb_write(input addr_t addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        chk.check_value("pready", 32'(pready), 32'h1);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input addr_t addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        chk.check_value("pready", 32'(pready), 32'h1);
        data = prdata;
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reset_state();
        chk.check_value("out_we", 32'(out_we), 32'h0);
        chk.check_value("done", 32'(done), 32'h0);
        chk.check_value("wt_addr0", 32'(wt_addr0), 32'h0);
        chk.check_value("wt_addr1", 32'(wt_addr1), 32'h0);
        chk.check_value("act_addr0", 32'(act_addr0), 32'h0);
        chk.check_value("act_addr1", 32'(act_addr1), 32'h0);
    endtask

    task automatic run_row(input test_row_t t);
        logic [31:0] rd;
        fill_memories(t);
        chk.expect_run(t.scale, t.sat);
        apb_write(REG_SCALE, t.scale);
        apb_read(REG_SCALE, rd);
        chk.check_value("prdata REG_SCALE", rd, t.scale);
        apb_write(REG_CTRL, 32'h1);
        // done from the previous run drops first
        wait (!done);
        wait (done);
        apb_read(REG_STATUS, rd);
        chk.check_value("prdata REG_STATUS", rd, 32'h1);
        chk.finish_run();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test table finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        wt_rdata0  = '0;
        wt_rdata1  = '0;
        act_rdata0 = '0;
        act_rdata1 = '0;
        table_rows[0] = make_row(32'h0001_0000, FILL_ONES, FILL_ONES, 0);
        table_rows[1] = make_row(32'h0001_0000, FILL_ALT, FILL_ONES, 0);
        table_rows[2] = make_row(32'h0000_0040, FILL_RAND, FILL_RAND, -1);
        table_rows[3] = make_row(32'h0010_0000, FILL_RAND, FILL_ALT, -1);
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        check_reset_state();
        for (int n = 0; n < ROWS; n++) begin
            run_row(table_rows[n]);
        end
        $display("run complete: %0d table rows, %0d errors", ROWS, chk.err_count);
        if (chk.err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
